/* Makefile */
# Verilator flow for the coefficient scaler

LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module coef_scaler_tb -f coef_scaler.f

sim:
	verilator --binary --assert --top-module coef_scaler_tb -f coef_scaler.f \
		-Mdir obj_dir -o coef_scaler_sim
	./obj_dir/coef_scaler_sim +verilator+error+limit+100 | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG) || \
		(echo "sim: pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* coef_scaler.f */
rtl/coef_pkg.sv
rtl/mod_mul_lane.sv
rtl/coef_special_mem.sv
rtl/coef_scale_engine.sv
rtl/coef_scaler_top.sv
sim/coef_scaler_checker.sv
sim/coef_scaler_monitor.sv
sim/coef_scaler_tb.sv

/* rtl/coef_pkg.sv */
/*
 * Coefficient scaler shared definitions
 * Holds the modulus, the bus and row widths, the register offsets
 * and the types that travel between the store and the scaling engine
 */
package coef_pkg;

    // ====================
    // Widths and modulus
    // ====================
    localparam int COEF_W = 24;
    localparam int HOST_W = 64;
    localparam int WIDE_W = 384;
    localparam int LANES  = 16;
    localparam int ROW_W  = 6;

    localparam logic [COEF_W-1:0] Q = 24'd8380417;

    // Register offsets above the last coefficient word
    localparam int CTRL_OFS   = 0;
    localparam int ENABLE_OFS = 1;
    localparam int STATUS_OFS = 2;

    // ====================
    // Types
    // ====================

    // One store word, read as a single coefficient or as two shares
    typedef union packed {
        struct packed {
            logic [39:0]       pad;
            logic [COEF_W-1:0] coef;
        } plain;
        struct packed {
            logic [15:0]       pad;
            logic [COEF_W-1:0] share1;
            logic [COEF_W-1:0] share0;
        } masked;
    } coef_word_u;

    typedef struct packed {
        logic [38:0]       reserved;
        logic              masked;
        logic [COEF_W-1:0] scalar;
    } ctrl_reg_t;

    typedef struct packed {
        logic              rd_en;
        logic [ROW_W-1:0]  rd_row;
        logic              wr_en;
        logic [ROW_W-1:0]  wr_row;
        logic [WIDE_W-1:0] wr_data;
    } wide_req_t;

endpackage

/* rtl/coef_scale_engine.sv */
/*
 * Coefficient scaling engine
 * Streams every row of the store through sixteen modular multiply lanes
 * and writes each row back three cycles after its read, then pulses done
 */
`timescale 1ns/1ps

module coef_scale_engine #(
    parameter int N_COEFFS = 256
) (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize,
    input  logic                        run_en,
    input  coef_pkg::ctrl_reg_t         ctrl,
    input  logic [coef_pkg::WIDE_W-1:0] rd_data,
    output coef_pkg::wide_req_t         wide,
    output logic                        done
);
    import coef_pkg::*;

    localparam int ROWS_PLAIN  = N_COEFFS / 4;
    localparam int ROWS_MASKED = N_COEFFS / 8;
    localparam int CNT_W       = ROW_W + 1;
    // Store read register plus two lane stages
    localparam int PIPE        = 3;

    logic              busy;
    logic              masked_q;
    logic [COEF_W-1:0] k_q;
    logic [CNT_W-1:0]  row_cnt;
    logic [CNT_W-1:0]  n_rows;
    logic              issue;
    logic              last_wr;
    logic [PIPE-1:0]   vld_q;
    logic [ROW_W-1:0]  row_q [PIPE];
    logic [WIDE_W-1:0] lane_y;

    // Row count follows the mode sampled at the start of the run
    assign n_rows  = masked_q ? CNT_W'(ROWS_MASKED) : CNT_W'(ROWS_PLAIN);
    assign issue   = busy && (row_cnt < n_rows);
    assign last_wr = vld_q[PIPE-1] && (CNT_W'(row_q[PIPE-1]) == n_rows - 1'b1);

    always_comb begin
        wide.rd_en   = issue;
        wide.rd_row  = row_cnt[ROW_W-1:0];
        wide.wr_en   = vld_q[PIPE-1];
        wide.wr_row  = row_q[PIPE-1];
        wide.wr_data = lane_y;
    end

    // ====================
    // Sequencer
    // ====================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy     <= 1'b0;
            masked_q <= 1'b0;
            k_q      <= '0;
            row_cnt  <= '0;
        end else if (zeroize) begin
            busy     <= 1'b0;
            masked_q <= 1'b0;
            k_q      <= '0;
            row_cnt  <= '0;
        end else if (!busy) begin
            if (run_en) begin
                busy     <= 1'b1;
                masked_q <= ctrl.masked;
                k_q      <= ctrl.scalar;
                row_cnt  <= '0;
            end
        end else begin
            if (issue) begin
                row_cnt <= row_cnt + 1'b1;
            end
            // The store drops enable on the same edge, so no restart follows
            if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // Valid bits of the rows in flight
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vld_q <= '0;
            done  <= 1'b0;
        end else if (zeroize) begin
            vld_q <= '0;
            done  <= 1'b0;
        end else begin
            vld_q <= {vld_q[PIPE-2:0], issue};
            done  <= last_wr;
        end
    end

    // Row numbers ride alongside the valid bits
    always_ff @(posedge clk) begin
        row_q[0] <= row_cnt[ROW_W-1:0];
        for (int i = 1; i < PIPE; i++) begin
            row_q[i] <= row_q[i-1];
        end
    end

    // ====================
    // Lanes
    // ====================
    for (genvar g = 0; g < LANES; g++) begin : g_lane
        mod_mul_lane u_lane (
            .clk     (clk),
            .reset_n (reset_n),
            .flush   (zeroize),
            .a       (rd_data[g*COEF_W +: COEF_W]),
            .k       (k_q),
            .y       (lane_y[g*COEF_W +: COEF_W])
        );
    end

endmodule

/* rtl/coef_scaler_top.sv */
/*
 * Coefficient scaler top level
 * Joins the coefficient store and the scaling engine behind one host port
 */
`timescale 1ns/1ps

module coef_scaler_top #(
    parameter int N_COEFFS = 256
) (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize,
    input  logic                        host_en,
    input  logic                        host_we,
    input  logic [$clog2(N_COEFFS):0]   host_addr,
    input  logic [coef_pkg::HOST_W-1:0] host_wdata,
    output logic [coef_pkg::HOST_W-1:0] host_rdata
);
    import coef_pkg::*;

    // Engine to store row traffic and the control handoff
    wide_req_t         wide;
    logic [WIDE_W-1:0] rd_data;
    ctrl_reg_t         ctrl;
    logic              run_en;
    logic              done;

    coef_special_mem #(
        .N_COEFFS (N_COEFFS)
    ) u_mem (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .host_en    (host_en),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .wide       (wide),
        .rd_data    (rd_data),
        .done       (done),
        .ctrl       (ctrl),
        .run_en     (run_en)
    );

    coef_scale_engine #(
        .N_COEFFS (N_COEFFS)
    ) u_engine (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .run_en  (run_en),
        .ctrl    (ctrl),
        .rd_data (rd_data),
        .wide    (wide),
        .done    (done)
    );

endmodule

/* rtl/coef_special_mem.sv */
/*
 * Coefficient special memory
 * Host side moves single 64-bit words, the engine side reads and writes
 * whole 384-bit rows, packed as plain coefficients or as share pairs
 */
`timescale 1ns/1ps

module coef_special_mem #(
    parameter int N_COEFFS = 256
) (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              zeroize,

    input  logic                              host_en,
    input  logic                              host_we,
    input  logic [$clog2(N_COEFFS):0]         host_addr,
    input  logic [coef_pkg::HOST_W-1:0]       host_wdata,
    output logic [coef_pkg::HOST_W-1:0]       host_rdata,

    input  coef_pkg::wide_req_t               wide,
    output logic [coef_pkg::WIDE_W-1:0]       rd_data,

    input  logic                              done,
    output coef_pkg::ctrl_reg_t               ctrl,
    output logic                              run_en
);
    import coef_pkg::*;

    localparam int CW = $clog2(N_COEFFS);
    localparam int AW = CW + 1;

    localparam logic [AW-1:0] CTRL_ADDR   = AW'(N_COEFFS + CTRL_OFS);
    localparam logic [AW-1:0] ENABLE_ADDR = AW'(N_COEFFS + ENABLE_OFS);
    localparam logic [AW-1:0] STATUS_ADDR = AW'(N_COEFFS + STATUS_OFS);

    coef_word_u        mem [N_COEFFS];
    ctrl_reg_t         ctrl_q;
    logic [HOST_W-1:0] enable_q;
    logic [HOST_W-1:0] status_q;

    logic [HOST_W-1:0] host_mux;
    logic [WIDE_W-1:0] pack_row;
    logic [CW-1:0]     rd_base_p;
    logic [CW-1:0]     rd_base_m;
    logic [CW-1:0]     wr_base_p;
    logic [CW-1:0]     wr_base_m;

    assign ctrl   = ctrl_q;
    assign run_en = enable_q[0];

    // First word of a row, four words per row in plain mode and eight when masked
    assign rd_base_p = CW'({wide.rd_row, 2'b00});
    assign rd_base_m = CW'({wide.rd_row, 3'b000});
    assign wr_base_p = CW'({wide.wr_row, 2'b00});
    assign wr_base_m = CW'({wide.wr_row, 3'b000});

    // ====================
    // Host read path
    // ====================
    always_comb begin
        if (host_addr < AW'(N_COEFFS)) begin
            host_mux = mem[host_addr[CW-1:0]];
        end else if (host_addr == CTRL_ADDR) begin
            host_mux = ctrl_q;
        end else if (host_addr == ENABLE_ADDR) begin
            host_mux = enable_q;
        end else if (host_addr == STATUS_ADDR) begin
            host_mux = status_q;
        end else begin
            host_mux = '0;
        end
    end

    // Row packing for the engine, share0 goes in the lower lane of each pair
    always_comb begin
        pack_row = '0;
        if (ctrl_q.masked) begin
            for (int j = 0; j < LANES / 2; j++) begin
                pack_row[(2*j)*COEF_W +: COEF_W]   = mem[rd_base_m + CW'(j)].masked.share0;
                pack_row[(2*j+1)*COEF_W +: COEF_W] = mem[rd_base_m + CW'(j)].masked.share1;
            end
        end else begin
            for (int j = 0; j < 4; j++) begin
                pack_row[j*COEF_W +: COEF_W] = mem[rd_base_p + CW'(j)].plain.coef;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            host_rdata <= '0;
            rd_data    <= '0;
        end else if (zeroize) begin
            host_rdata <= '0;
            rd_data    <= '0;
        end else begin
            // Read data only lives for the cycle after the strobe
            host_rdata <= host_en ? host_mux : '0;
            if (wide.rd_en) begin
                rd_data <= pack_row;
            end
        end
    end

    // ====================
    // Store updates
    // ====================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < N_COEFFS; i++) begin
                mem[i] <= '0;
            end
            ctrl_q   <= '0;
            enable_q <= '0;
            status_q <= '0;
        end else if (zeroize) begin
            for (int i = 0; i < N_COEFFS; i++) begin
                mem[i] <= '0;
            end
            ctrl_q   <= '0;
            enable_q <= '0;
            status_q <= '0;
        end else begin
            if (host_we) begin
                if (host_addr < AW'(N_COEFFS)) begin
                    mem[host_addr[CW-1:0]] <= host_wdata;
                end else if (host_addr == CTRL_ADDR) begin
                    ctrl_q <= ctrl_reg_t'(host_wdata);
                end else if (host_addr == ENABLE_ADDR) begin
                    enable_q <= host_wdata;
                    // A new run request forgets the previous completion
                    if (host_wdata[0]) begin
                        status_q <= '0;
                    end
                end else if (host_addr == STATUS_ADDR) begin
                    status_q <= host_wdata;
                end
            end

            // Row write-back splits the row and clears the bits above each field
            if (wide.wr_en) begin
                if (ctrl_q.masked) begin
                    for (int j = 0; j < LANES / 2; j++) begin
                        mem[wr_base_m + CW'(j)].masked.pad    <= '0;
                        mem[wr_base_m + CW'(j)].masked.share1 <=
                            wide.wr_data[(2*j+1)*COEF_W +: COEF_W];
                        mem[wr_base_m + CW'(j)].masked.share0 <=
                            wide.wr_data[(2*j)*COEF_W +: COEF_W];
                    end
                end else begin
                    for (int j = 0; j < 4; j++) begin
                        mem[wr_base_p + CW'(j)].plain.pad  <= '0;
                        mem[wr_base_p + CW'(j)].plain.coef <= wide.wr_data[j*COEF_W +: COEF_W];
                    end
                end
            end

            if (done) begin
                status_q <= HOST_W'(1);
                enable_q <= '0;
            end
        end
    end

endmodule

/* rtl/mod_mul_lane.sv */
/*
 * Modular multiply lane
 * Two-stage pipeline computing a times k modulo Q, one new value per cycle
 */
`timescale 1ns/1ps

module mod_mul_lane (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        flush,
    input  logic [coef_pkg::COEF_W-1:0] a,
    input  logic [coef_pkg::COEF_W-1:0] k,
    output logic [coef_pkg::COEF_W-1:0] y
);
    import coef_pkg::*;

    logic [2*COEF_W-1:0] prod_q;

    // Stage one holds the full product
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
        end else if (flush) begin
            prod_q <= '0;
        end else begin
            prod_q <= a * k;
        end
    end

    // Stage two reduces it, the remainder always fits in a coefficient
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            y <= '0;
        end else if (flush) begin
            y <= '0;
        end else begin
            y <= COEF_W'(prod_q % Q);
        end
    end

endmodule

/* sim/coef_scaler_checker.sv */
/*
 * Scaling engine protocol checker
 * Bound into the engine, watches done and the row request strobes
 */
`timescale 1ns/1ps

module coef_scaler_checker (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize,
    input  logic                done,
    input  coef_pkg::wide_req_t wide
);
    int fail_cnt = 0;

    // Done is a single-cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        done |-> !$past(done))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("done was high for more than one cycle");
        end

    // Every read comes back as a write three cycles later, unless zeroize flushed it
    wr_follows_rd: assert property (@(posedge clk) disable iff (!reset_n)
        (!$past(zeroize, 1) && !$past(zeroize, 2) && !$past(zeroize, 3))
            |-> (wide.wr_en == $past(wide.rd_en, 3)))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("wide.wr_en does not follow wide.rd_en by three cycles");
        end

    no_read_at_done: assert property (@(posedge clk) disable iff (!reset_n)
        done |-> !$rose(wide.rd_en))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("wide.rd_en rose while done was high");
        end

endmodule

bind coef_scale_engine coef_scaler_checker chk (
    .clk     (clk),
    .reset_n (reset_n),
    .zeroize (zeroize),
    .done    (done),
    .wide    (wide)
);

/* sim/coef_scaler_monitor.sv */
/*
 * Host port monitor
 * Shadows every word and register from observed host writes, scales the
 * shadow when the engine finishes and checks each read one cycle later
 */
`timescale 1ns/1ps

module coef_scaler_monitor #(
    parameter int N_COEFFS = 256
) (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize,
    input  logic                        host_en,
    input  logic                        host_we,
    input  logic [$clog2(N_COEFFS):0]   host_addr,
    input  logic [coef_pkg::HOST_W-1:0] host_wdata,
    input  logic [coef_pkg::HOST_W-1:0] host_rdata,
    input  logic                        done
);
    import coef_pkg::*;

    localparam int AW     = $clog2(N_COEFFS) + 1;
    localparam int N_REGS = N_COEFFS + 3;

    logic [HOST_W-1:0] shadow [N_REGS];
    logic              rd_pending;
    logic [AW-1:0]     exp_addr;
    logic [HOST_W-1:0] exp_data;
    logic [COEF_W-1:0] run_k;
    logic              run_masked;
    int                pass_cnt = 0;
    int                err_cnt = 0;

    // Expected word after one run: each field times k modulo Q, upper bits cleared
    function automatic logic [HOST_W-1:0] scale_word(input logic [HOST_W-1:0] word,
                                                     input logic [COEF_W-1:0] k,
                                                     input logic              masked);
        logic [2*COEF_W-1:0] p0;
        logic [2*COEF_W-1:0] p1;
        logic [HOST_W-1:0]   r;
        p0 = 48'(word[COEF_W-1:0]) * 48'(k);
        p1 = 48'(word[2*COEF_W-1:COEF_W]) * 48'(k);
        r = '0;
        r[COEF_W-1:0] = COEF_W'(p0 % 48'(Q));
        if (masked) begin
            r[2*COEF_W-1:COEF_W] = COEF_W'(p1 % 48'(Q));
        end
        return r;
    endfunction

    function automatic logic [HOST_W-1:0] shadow_read(input logic [AW-1:0] addr);
        if (int'(addr) < N_REGS) begin
            return shadow[addr];
        end
        return '0;
    endfunction

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < N_REGS; i++) begin
                shadow[i] = '0;
            end
            rd_pending = 1'b0;
            exp_addr   = '0;
            exp_data   = '0;
            run_k      = '0;
            run_masked = 1'b0;
        end else begin
            // ====================
            // Compare the read issued one cycle ago
            // ====================
            if (rd_pending) begin
                if (host_rdata === exp_data) begin
                    pass_cnt++;
                end else begin
                    err_cnt++;
                    $display("ERR host_rdata addr=%h expected=%h got=%h",
                             exp_addr, exp_data, host_rdata);
                end
            end else if (host_rdata !== '0) begin
                err_cnt++;
                $display("ERR host_rdata idle expected=%h got=%h", {HOST_W{1'b0}}, host_rdata);
            end

            if (zeroize) begin
                for (int i = 0; i < N_REGS; i++) begin
                    shadow[i] = '0;
                end
                rd_pending = 1'b0;
            end else begin
                // Reads see the state from before this edge
                rd_pending = host_en;
                exp_addr   = host_addr;
                exp_data   = shadow_read(host_addr);

                if (host_we && int'(host_addr) < N_REGS) begin
                    shadow[host_addr] = host_wdata;
                    if (int'(host_addr) == N_COEFFS + ENABLE_OFS && host_wdata[0]) begin
                        shadow[N_COEFFS + STATUS_OFS] = '0;
                        run_k      = shadow[N_COEFFS + CTRL_OFS][COEF_W-1:0];
                        run_masked = shadow[N_COEFFS + CTRL_OFS][COEF_W];
                    end
                end

                if (done) begin
                    for (int i = 0; i < N_COEFFS; i++) begin
                        shadow[i] = scale_word(shadow[i], run_k, run_masked);
                    end
                    shadow[N_COEFFS + STATUS_OFS] = HOST_W'(1);
                    shadow[N_COEFFS + ENABLE_OFS] = '0;
                end
            end
        end
    end

endmodule

/* sim/coef_scaler_tb.sv */
/*
 * Coefficient scaler testbench
 * Runs reset, readback, plain and masked scaling, a rerun on scaled data
 * and zeroize through the host port, then reports the totals
 */
`timescale 1ns/1ps

module coef_scaler_tb;
    import coef_pkg::*;

    localparam int N_COEFFS  = 256;
    localparam int AW        = $clog2(N_COEFFS) + 1;
    localparam int NUM_TESTS = 6;
    localparam longint WATCHDOG_NS = longint'(NUM_TESTS) * (4 * N_COEFFS + 200) * 100;

    localparam logic [AW-1:0] CTRL_ADDR     = AW'(N_COEFFS + CTRL_OFS);
    localparam logic [AW-1:0] ENABLE_ADDR   = AW'(N_COEFFS + ENABLE_OFS);
    localparam logic [AW-1:0] STATUS_ADDR   = AW'(N_COEFFS + STATUS_OFS);
    localparam logic [AW-1:0] UNMAPPED_ADDR = AW'(N_COEFFS + 3);

    logic              clk;
    logic              reset_n;
    logic              zeroize;
    logic              host_en;
    logic              host_we;
    logic [AW-1:0]     host_addr;
    logic [HOST_W-1:0] host_wdata;
    logic [HOST_W-1:0] host_rdata;

    logic [31:0]       lfsr_state;
    logic [HOST_W-1:0] orig [N_COEFFS];
    logic [COEF_W-1:0] k_run;
    int                tb_err;
    int                tb_pass;
    int                err_base;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    coef_scaler_top #(.N_COEFFS(N_COEFFS)) dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .host_en    (host_en),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

    coef_scaler_monitor #(.N_COEFFS(N_COEFFS)) mon (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .host_en    (host_en),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .done       (dut.done)
    );

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    // ====================
    // Helpers
    // ====================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int total_errors();
        return mon.err_cnt + tb_err + dut.u_engine.chk.fail_cnt;
    endfunction

    // Bus tasks start and end on a falling edge, one cycle per access
    task automatic host_write(input logic [AW-1:0] addr, input logic [HOST_W-1:0] data);
        host_we    = 1'b1;
        host_addr  = addr;
        host_wdata = data;
        @(negedge clk);
        host_we = 1'b0;
    endtask

    task automatic host_read(input logic [AW-1:0] addr, output logic [HOST_W-1:0] data);
        host_en   = 1'b1;
        host_addr = addr;
        @(negedge clk);
        host_en = 1'b0;
        data    = host_rdata;
    endtask

    task automatic read_range(input int count);
        logic [HOST_W-1:0] d;
        for (int i = 0; i < count; i++) begin
            host_read(AW'(i), d);
        end
    endtask

    task automatic wait_status_set();
        logic [HOST_W-1:0] d;
        d = '0;
        while (d[0] !== 1'b1) begin
            host_read(STATUS_ADDR, d);
        end
    endtask

    task automatic load_and_start(input logic masked);
        ctrl_reg_t c;
        for (int i = 0; i < N_COEFFS; i++) begin
            orig[i] = take_bits(HOST_W);
            host_write(AW'(i), orig[i]);
        end
        k_run    = COEF_W'(take_bits(COEF_W));
        c        = '0;
        c.masked = masked;
        c.scalar = k_run;
        host_write(CTRL_ADDR, c);
        host_write(ENABLE_ADDR, HOST_W'(1));
    endtask

    // Share pairs must still add up to the scaled sum of the originals
    task automatic check_share_sums();
        logic [HOST_W-1:0] d;
        logic [63:0]       exp_sum;
        logic [63:0]       got_sum;
        for (int i = 0; i < N_COEFFS; i++) begin
            host_read(AW'(i), d);
            exp_sum = 64'(orig[i][COEF_W-1:0]) + 64'(orig[i][2*COEF_W-1:COEF_W]);
            exp_sum = (exp_sum * 64'(k_run)) % 64'(Q);
            got_sum = (64'(d[COEF_W-1:0]) + 64'(d[2*COEF_W-1:COEF_W])) % 64'(Q);
            if (got_sum === exp_sum) begin
                tb_pass++;
            end else begin
                tb_err++;
                $display("ERR share_sum word=%0d expected=%h got=%h", i, exp_sum, got_sum);
            end
        end
    endtask

    task automatic end_test(input int num, input string name);
        int errs;
        @(negedge clk);
        errs = total_errors() - err_base;
        if (errs == 0) begin
            $display("test %0d %s: PASS", num, name);
        end else begin
            $display("test %0d %s: FAIL with %0d errors", num, name, errs);
        end
        err_base = total_errors();
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        logic [HOST_W-1:0] d;
        logic [AW-1:0]     a;
        reset_n    = 1'b0;
        zeroize    = 1'b0;
        host_en    = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        lfsr_state = 32'h1d04dbde;
        tb_err     = 0;
        tb_pass    = 0;
        err_base   = 0;
        repeat (10) @(negedge clk);
        reset_n = 1'b1;

        read_range(N_COEFFS + 3);
        end_test(1, "reset values");

        for (int i = 0; i < 32; i++) begin
            a = AW'(take_bits(AW - 1));
            host_write(a, take_bits(HOST_W));
            host_read(a, d);
        end
        host_write(CTRL_ADDR, take_bits(HOST_W));
        host_read(CTRL_ADDR, d);
        host_write(UNMAPPED_ADDR, take_bits(HOST_W));
        host_read(UNMAPPED_ADDR, d);
        end_test(2, "host readback");

        load_and_start(1'b0);
        wait_status_set();
        read_range(N_COEFFS);
        host_read(ENABLE_ADDR, d);
        end_test(3, "plain run");

        load_and_start(1'b1);
        wait_status_set();
        check_share_sums();
        end_test(4, "masked run");

        // Status must drop right away, long before the rerun completes
        host_write(ENABLE_ADDR, HOST_W'(1));
        host_read(STATUS_ADDR, d);
        wait_status_set();
        read_range(N_COEFFS);
        end_test(5, "status clear and rerun");

        zeroize = 1'b1;
        @(negedge clk);
        zeroize = 1'b0;
        read_range(N_COEFFS + 3);
        end_test(6, "zeroize");

        $display("checks passed %0d, errors %0d", mon.pass_cnt + tb_pass, total_errors());
        if (total_errors() == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
